// ==== hdl/lcd_pkg.sv ====
package lcd_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	localparam int DATA_W  = 8;	// Panel bus, 8-bit mode
	localparam int DIGIT_W = 5;
	localparam int POS_W   = 5;

	typedef logic [DATA_W-1:0]  lcd_byte_t;
	typedef logic [DIGIT_W-1:0] digit_t;
	typedef logic [POS_W-1:0]   pos_t;

	////////////////////////////////////////////////////////////////////////////
	// Message constants
	////////////////////////////////////////////////////////////////////////////

	// One address command followed by 16 characters
	localparam int MSG_LEN = 17;

	localparam digit_t DIGIT_MAX = 5'd24;	// 'A' + 24 = 'Y'

	localparam lcd_byte_t CMD_HOME    = 8'h80;	// Set DDRAM address 0
	localparam lcd_byte_t CHR_SPACE   = 8'h20;
	localparam lcd_byte_t CHR_COLON   = 8'h3A;
	localparam lcd_byte_t CHR_A       = 8'h41;
	localparam lcd_byte_t CHR_UNKNOWN = 8'h3F;	// '?'

	////////////////////////////////////////////////////////////////////////////
	// Enums
	////////////////////////////////////////////////////////////////////////////

	// Value is what goes out on rs
	typedef enum logic [0:0] {
		OP_CMD  = 1'b0,
		OP_DATA = 1'b1
	} lcd_op_e;

	typedef enum logic [1:0] {
		SEQ_IDLE = 2'd0,
		SEQ_REQ  = 2'd1,	// req high, waiting for ack
		SEQ_WAIT = 2'd2	// req low, waiting for ack to drop
	} seq_state_e;

endpackage

// ==== hdl/lcd_wr_if.sv ====
interface lcd_wr_if;
	import lcd_pkg::*;

	// Four-phase handshake, one panel write per transfer
	logic		req;
	lcd_op_e	op;	// Valid while req is high
	lcd_byte_t	data;	// Valid while req is high
	logic		ack;

	// Sequencer side
	modport src (
		output	req,
		output	op,
		output	data,
		input	ack
	);

	// Bus register side
	modport dst (
		input	req,
		input	op,
		input	data,
		output	ack
	);

endinterface

// ==== hdl/lcd_strobe_gen.sv ====
module lcd_strobe_gen #(
	parameter int HALF_PERIOD = 25000
) (
	input	logic	clk,
	input	logic	rstn,
	input	logic	en,
	output	logic	lcd_en,
	output	logic	tick
);

	localparam int CNT_W = $clog2(HALF_PERIOD);
	localparam logic [CNT_W-1:0] CNT_RELOAD = CNT_W'(HALF_PERIOD - 1);

	logic	[CNT_W-1:0]	cnt;
	logic			cnt_zero;

	assign cnt_zero = (cnt == '0);

	////////////////////////////////////////////////////////////////////////////
	// Half-period down-counter and strobe phase
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cnt    <= CNT_RELOAD;	// Full low phase out of reset
			lcd_en <= 1'b0;
		end else if (!en) begin
			cnt    <= '0;	// Parked, strobe held low
			lcd_en <= 1'b0;
		end else if (cnt_zero) begin
			cnt    <= CNT_RELOAD;
			lcd_en <= ~lcd_en;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// Last cycle of the high phase, strobe falls at the end of it
	assign tick = en & lcd_en & cnt_zero;

endmodule

// ==== hdl/lcd_msg_rom.sv ====
module lcd_msg_rom (
	input	lcd_pkg::pos_t		pos,
	input	lcd_pkg::digit_t	digit,
	output	lcd_pkg::lcd_op_e	op,
	output	lcd_pkg::lcd_byte_t	data
);
	import lcd_pkg::*;

	lcd_byte_t	letter;

	// Letters stop at 'Y', anything past that shows '?'
	assign letter = (digit <= DIGIT_MAX) ? CHR_A + lcd_byte_t'(digit) : CHR_UNKNOWN;

	////////////////////////////////////////////////////////////////////////////
	// "    INDEX : x   " behind one address command
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		op   = OP_DATA;
		data = CHR_SPACE;	// Leading and trailing blanks
		case (pos)
			5'd0: begin
				op   = OP_CMD;
				data = CMD_HOME;
			end
			5'd5:  data = 8'h49;	// I
			5'd6:  data = 8'h4E;	// N
			5'd7:  data = 8'h44;	// D
			5'd8:  data = 8'h45;	// E
			5'd9:  data = 8'h58;	// X
			5'd11: data = CHR_COLON;
			5'd13: data = letter;
			default: begin
				op   = OP_DATA;
				data = CHR_SPACE;
			end
		endcase
	end

endmodule

// ==== hdl/lcd_write_seq.sv ====
module lcd_write_seq (
	input	logic			clk,
	input	logic			rstn,
	input	logic			go,
	input	logic			en,
	input	lcd_pkg::digit_t	digit,
	lcd_wr_if.src			wr
);
	import lcd_pkg::*;

	localparam pos_t LAST_POS = pos_t'(MSG_LEN - 1);

	seq_state_e	state;
	pos_t		pos;
	digit_t		digit_q;
	lcd_op_e	rom_op;
	lcd_byte_t	rom_data;
	logic		last;

	assign last = (pos == LAST_POS);

	////////////////////////////////////////////////////////////////////////////
	// Refresh FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= SEQ_IDLE;
			pos   <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (go && en) begin	// go while running is ignored
						pos   <= '0;
						state <= SEQ_REQ;
					end
				end
				SEQ_REQ: begin
					// Hold the write until the port takes it
					if (wr.ack)
						state <= SEQ_WAIT;
				end
				SEQ_WAIT: begin
					if (!wr.ack) begin
						if (last) begin
							state <= SEQ_IDLE;
						end else begin
							pos   <= pos + 1'b1;
							state <= SEQ_REQ;
						end
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// Digit is frozen for the whole refresh
	always_ff @(posedge clk) begin
		if (state == SEQ_IDLE && go && en)
			digit_q <= digit;
	end

	lcd_msg_rom u_msg_rom (
		.pos	(pos),
		.digit	(digit_q),
		.op	(rom_op),
		.data	(rom_data)
	);

	assign wr.req  = (state == SEQ_REQ);
	assign wr.op   = rom_op;	// Stable while req, pos only moves in SEQ_WAIT
	assign wr.data = rom_data;

endmodule

// ==== hdl/lcd_port.sv ====
module lcd_port (
	input	logic			clk,
	input	logic			rstn,
	input	logic			tick,
	lcd_wr_if.dst			wr,
	output	logic			lcd_rs,
	output	logic			lcd_rw,
	output	lcd_pkg::lcd_byte_t	lcd_dout
);
	import lcd_pkg::*;

	logic	accept;

	// A write is only taken at a strobe falling edge
	assign accept = tick & wr.req & ~wr.ack;

	////////////////////////////////////////////////////////////////////////////
	// Panel bus registers and ack
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			lcd_rs   <= 1'b0;
			lcd_dout <= '0;
			wr.ack   <= 1'b0;
		end else if (accept) begin
			lcd_rs   <= (wr.op == OP_DATA);
			lcd_dout <= wr.data;	// Held for the next full strobe period
			wr.ack   <= 1'b1;
		end else if (wr.ack && !wr.req) begin
			wr.ack <= 1'b0;	// Return to zero
		end
	end

	// Write-only panel
	assign lcd_rw = 1'b0;

endmodule

// ==== hdl/text_lcd.sv ====
module text_lcd #(
	parameter int HALF_PERIOD = 25000
) (
	input	logic			clk,
	input	logic			rstn,
	input	logic			go,
	input	logic			en,
	input	lcd_pkg::digit_t	digit,

	output	logic			lcd_en,
	output	logic			lcd_rs,
	output	logic			lcd_rw,
	output	logic			lcd_on,
	output	lcd_pkg::lcd_byte_t	lcd_dout
);

	logic	tick;

	lcd_wr_if wr ();

	////////////////////////////////////////////////////////////////////////////
	// Strobe, sequencer and bus register
	////////////////////////////////////////////////////////////////////////////

	lcd_strobe_gen #(
		.HALF_PERIOD	(HALF_PERIOD)
	) u_strobe_gen (
		.clk	(clk),
		.rstn	(rstn),
		.en	(en),
		.lcd_en	(lcd_en),
		.tick	(tick)
	);

	lcd_write_seq u_write_seq (
		.clk	(clk),
		.rstn	(rstn),
		.go	(go),
		.en	(en),
		.digit	(digit),
		.wr	(wr.src)
	);

	lcd_port u_port (
		.clk		(clk),
		.rstn		(rstn),
		.tick		(tick),
		.wr		(wr.dst),
		.lcd_rs		(lcd_rs),
		.lcd_rw		(lcd_rw),
		.lcd_dout	(lcd_dout)
	);

	// Backlight/power follows the enable input
	assign lcd_on = en;

endmodule

// ==== sim/text_lcd_assertions.sv ====
module text_lcd_assertions (
	input	logic	clk,
	input	logic	rstn,
	input	logic	tick,
	input	logic	req,
	input	logic	ack
);

	////////////////////////////////////////////////////////////////////////////
	// Write handshake
	////////////////////////////////////////////////////////////////////////////

	// ack only answers a live request
	ack_with_req: assert property (@(posedge clk) disable iff (!rstn)
		$rose(ack) |-> req)
		else $error("ack rose while req was low");

	req_held: assert property (@(posedge clk) disable iff (!rstn)
		req && !ack |=> req)	// No withdrawing a write
		else $error("req dropped before ack arrived");

	////////////////////////////////////////////////////////////////////////////
	// Strobe timing
	////////////////////////////////////////////////////////////////////////////

	ack_after_tick: assert property (@(posedge clk) disable iff (!rstn)
		$rose(ack) |-> $past(tick))
		else $error("ack rose without a tick in the cycle before");

endmodule

bind lcd_port text_lcd_assertions u_assertions (
	.clk	(clk),
	.rstn	(rstn),
	.tick	(tick),
	.req	(wr.req),
	.ack	(wr.ack)
);

// ==== sim/tb_text_lcd.sv ====
module tb_text_lcd;
	import lcd_pkg::*;

	localparam int HALF_PERIOD = 4;
	localparam int STROBE_CYC  = 2 * HALF_PERIOD;
	localparam int N_RAND      = 30;
	localparam int N_REFRESH   = N_RAND + 9;	// Random, 7 unknown letters, double go, after en
	localparam int N_RUNS      = N_REFRESH + 1;	// Plus the en low run
	localparam int CYCLE_LIMIT = N_RUNS * 24 * STROBE_CYC + 200;

	logic		clk;
	logic		rstn;
	logic		go;
	logic		en;
	digit_t		digit;
	logic		lcd_en;
	logic		lcd_rs;
	logic		lcd_rw;
	logic		lcd_on;
	lcd_byte_t	lcd_dout;

	logic	[31:0]		rng_state;
	logic	[DATA_W:0]	samples[$];	// {rs, dout} at each lcd_en rising edge
	logic	[DATA_W:0]	bus_last;	// What the bus shows between refreshes
	logic			en_prev;
	int			cycles = 0;
	bit			msg_done;

	text_lcd #(
		.HALF_PERIOD	(HALF_PERIOD)
	) uut (
		.clk		(clk),
		.rstn		(rstn),
		.go		(go),
		.en		(en),
		.digit		(digit),
		.lcd_en		(lcd_en),
		.lcd_rs		(lcd_rs),
		.lcd_rw		(lcd_rw),
		.lcd_on		(lcd_on),
		.lcd_dout	(lcd_dout)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Error exit, watchdog and compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		msg_done = 1'b1;
		$fatal(1, "Run stopped at the first error");
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			abort_run($sformatf("Timeout, tests not finished after %0d cycles", cycles));
	end

	// Assertion stops end the run here
	final begin
		if (!msg_done)
			$display("sim failed");
	end

	task automatic check_byte(input string name, input lcd_byte_t exp, input lcd_byte_t act);
		if (act !== exp)
			abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_op(input string name, input lcd_op_e exp, input logic act);
		if (act !== logic'(exp))
			abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model and random numbers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic lcd_op_e exp_op(input int pos);
		return (pos == 0) ? OP_CMD : OP_DATA;
	endfunction

	function automatic lcd_byte_t exp_byte(input int pos, input digit_t d);
		string line;
		string letters;
		line    = "    INDEX : *   ";	// Display row, '*' is the letter slot
		letters = "ABCDEFGHIJKLMNOPQRSTUVWXY";	// One letter per digit
		if (pos == 0)
			return CMD_HOME;
		if (pos == 13) begin
			if (int'(d) < letters.len())
				return lcd_byte_t'(letters[d]);
			return CHR_UNKNOWN;
		end
		return lcd_byte_t'(line[pos-1]);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// One clock, inputs change after this returns
	task automatic step();
		@(negedge clk);
		check_bit("lcd_rw", 1'b0, lcd_rw);
		check_bit("lcd_on", en, lcd_on);
		if (lcd_en && !en_prev)
			samples.push_back({lcd_rs, lcd_dout});
		en_prev = lcd_en;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) step();
	endtask

	task automatic next_sample(output logic [DATA_W:0] s);
		while (samples.size() == 0)
			step();
		s = samples.pop_front();
	endtask

	task automatic check_bus_low();
		check_bit("lcd_en", 1'b0, lcd_en);
		check_op("lcd_rs", OP_CMD, lcd_rs);
		check_bit("lcd_rw", 1'b0, lcd_rw);
		check_byte("lcd_dout", '0, lcd_dout);
	endtask

	task automatic run_refresh(input digit_t d, input bit second_go);
		logic [DATA_W:0] s;
		int pos;
		samples.delete();
		go    = 1'b1;
		digit = d;
		step();
		go    = 1'b0;
		digit = digit_t'(next_rand());	// Captured digit must not change
		next_sample(s);
		while (s == bus_last)	// Old contents until the first write lands
			next_sample(s);
		for (pos = 0; pos < MSG_LEN; pos++) begin
			if (pos > 0)
				next_sample(s);
			check_op("lcd_rs", exp_op(pos), s[DATA_W]);
			check_byte("lcd_dout", exp_byte(pos, d), s[DATA_W-1:0]);
			if (second_go && pos == 5) begin
				go    = 1'b1;
				digit = digit_t'(next_rand());
				step();
				go = 1'b0;
			end
		end
		bus_last = {logic'(exp_op(MSG_LEN - 1)), exp_byte(MSG_LEN - 1, d)};
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [DATA_W:0] s;
		int v;
		int i;
		int n_seen;
		clk       = 1'b0;
		rstn      = 1'b0;
		go        = 1'b0;
		en        = 1'b1;
		digit     = '0;
		rng_state = 32'd55;
		bus_last  = '0;	// Reset value of rs and dout
		en_prev   = 1'b0;
		msg_done  = 1'b0;

		repeat (5) begin
			step();
			check_bus_low();
		end
		rstn = 1'b1;
		step();
		check_bus_low();

		// Random letters, random gaps
		repeat (N_RAND) begin
			run_refresh(digit_t'(next_rand() % 25), 1'b0);
			idle_cycles(int'(next_rand() % 16));
		end

		for (v = 25; v < 32; v++) begin
			run_refresh(digit_t'(v), 1'b0);
			idle_cycles(int'(next_rand() % 16));
		end

		// go in the middle of a refresh
		run_refresh(digit_t'(next_rand() % 25), 1'b1);
		repeat (4) begin
			next_sample(s);
			check_op("lcd_rs", OP_DATA, s[DATA_W]);
			check_byte("lcd_dout", CHR_SPACE, s[DATA_W-1:0]);
		end

		// Panel off, go has no effect
		en = 1'b0;
		for (i = 0; i < 6 * STROBE_CYC; i++) begin
			go = (i == 2 * STROBE_CYC);
			step();
			check_bit("lcd_en", 1'b0, lcd_en);
		end
		go = 1'b0;
		en = 1'b1;
		samples.delete();
		idle_cycles(6 * STROBE_CYC);
		n_seen = 0;
		while (samples.size() > 0) begin
			s = samples.pop_front();
			check_op("lcd_rs", OP_DATA, s[DATA_W]);
			check_byte("lcd_dout", bus_last[DATA_W-1:0], s[DATA_W-1:0]);
			n_seen++;
		end
		if (n_seen == 0)
			abort_run("lcd_en did not toggle again after en went high");
		run_refresh(digit_t'(next_rand() % 25), 1'b0);

		$display("sim passed");
		msg_done = 1'b1;
		$finish;
	end

endmodule

// ==== files.f ====
hdl/lcd_pkg.sv
hdl/lcd_wr_if.sv
hdl/lcd_strobe_gen.sv
hdl/lcd_msg_rom.sv
hdl/lcd_write_seq.sv
hdl/lcd_port.sv
hdl/text_lcd.sv
sim/text_lcd_assertions.sv
sim/tb_text_lcd.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the text LCD testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
	--top-module tb_text_lcd \
	--Mdir obj_dir \
	-f files.f

# Result is read from the log below
./obj_dir/Vtb_text_lcd 2>&1 | tee "$LOG"

if grep -q "sim failed" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi

if ! grep -q "sim passed" "$LOG"; then
	echo "Simulation ended without a result, see $LOG"
	exit 1
fi

echo "Simulation clean"
